// File: hw/ib_defs.svh
// size and address macros for the instruction buffer, included by every file that needs them
`ifndef IB_DEFS_SVH
`define IB_DEFS_SVH

// number of buffer entries, the shift and slot logic is written for four
`define IB_DEPTH 4

// instruction word width
`define INSTR_W 32

// halfword pc, bit 0 of the byte address is dropped
`define PC_W 31

// csr address that a debug write turns into a fence
`define DBG_FENCE_CSR 12'h7c4

`endif

// File: hw/ib_pkg.sv
// buffer content types and the retire shift encoding, used by the buffer RTL and the checker
`include "ib_defs.svh"

package ib_pkg;

   typedef logic [`INSTR_W-1:0] instr_t;   // raw instruction word
   typedef logic [`PC_W-1:0]    pc_t;      // halfword pc

   // one buffer entry as it is stored
   typedef struct packed {
      instr_t instr;
      pc_t    pc;
      logic   pc4;    // 4-byte instruction, else 2-byte
      logic   icaf;   // instruction access fault
   } entry_t;

   // entries retired by decode in one cycle
   typedef enum logic [1:0] {
      SHIFT_NONE,
      SHIFT_ONE,
      SHIFT_TWO
   } shift_e;

endpackage

// File: hw/dbg_pkg.sv
// debug command kinds and injected instruction templates, used by the debug injector and its checker
package dbg_pkg;

   // abstract command type as sent by the debug module
   typedef enum logic [1:0] {
      DBG_GPR = 2'd0,
      DBG_CSR = 2'd1,
      DBG_MEM = 2'd2   // memory access, serviced outside the buffer
   } dbg_type_e;

   // which instruction gets built for a command
   typedef enum logic [2:0] {
      OP_NONE,
      OP_GPR_RD,   // or  x0, reg, x0
      OP_GPR_WR,   // or  reg, x0, x0
      OP_CSR_RD,   // csrrs x0, csr, x0
      OP_CSR_WR    // csrrw x0, csr, x0
   } dbg_op_e;

endpackage

// File: hw/dbg_inst_gen.sv
// turns an abstract debug gpr or csr command into an instruction for the head of the buffer
`timescale 1ns/100ps
`include "ib_defs.svh"

module dbg_inst_gen (
   input  logic                clk,
   input  logic                reset,
   input  logic                dbg_cmd_valid,
   input  logic                dbg_cmd_write,
   input  dbg_pkg::dbg_type_e  dbg_cmd_type,
   input  logic [11:0]         dbg_cmd_addr,
   output logic                dbg_inject_valid,
   output logic [`INSTR_W-1:0] dbg_inject_instr,
   output logic                dbg_wdata_rs1,
   output logic                dbg_fence
);

   dbg_pkg::dbg_op_e op;
   logic [4:0]       dreg;
   logic [11:0]      dcsr;

   assign dreg = dbg_cmd_addr[4:0];
   assign dcsr = dbg_cmd_addr;

   // classify the command, memory commands fall through to none
   always_comb begin
      op = dbg_pkg::OP_NONE;
      if (dbg_cmd_valid) begin
         if (dbg_cmd_type == dbg_pkg::DBG_GPR) begin
            if (dbg_cmd_write) op = dbg_pkg::OP_GPR_WR;
            else op = dbg_pkg::OP_GPR_RD;
         end else if (dbg_cmd_type == dbg_pkg::DBG_CSR) begin
            if (dbg_cmd_write) op = dbg_pkg::OP_CSR_WR;
            else op = dbg_pkg::OP_CSR_RD;
         end
      end
   end

   assign dbg_inject_valid = (op != dbg_pkg::OP_NONE);

   // fields are funct7/csr, rs2, rs1, funct3, rd, opcode
   always_comb begin
      case (op)
         dbg_pkg::OP_GPR_RD: dbg_inject_instr = {7'b0, 5'd0, dreg, 3'b110, 5'd0, 7'b0110011};
         dbg_pkg::OP_GPR_WR: dbg_inject_instr = {7'b0, 5'd0, 5'd0, 3'b110, dreg, 7'b0110011};
         dbg_pkg::OP_CSR_RD: dbg_inject_instr = {dcsr, 5'd0, 3'b010, 5'd0, 7'b1110011};
         dbg_pkg::OP_CSR_WR: dbg_inject_instr = {dcsr, 5'd0, 3'b001, 5'd0, 7'b1110011};
         default:            dbg_inject_instr = '0;
      endcase
   end

   // core is halted, so the write data is needed on rs1 in the very next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         dbg_wdata_rs1 <= 1'b0;
         dbg_fence     <= 1'b0;
      end else begin
         dbg_wdata_rs1 <= (op == dbg_pkg::OP_GPR_WR) || (op == dbg_pkg::OP_CSR_WR);
         dbg_fence     <= (op == dbg_pkg::OP_CSR_WR) && (dcsr == `DBG_FENCE_CSR);
      end
   end

endmodule

// File: hw/ib_slot_ctl.sv
// tracks which buffer entries hold instructions and steers every write and retire shift
`timescale 1ns/100ps
`include "ib_defs.svh"

module ib_slot_ctl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 flush,
   input  logic                 fetch_i0_valid,
   input  logic                 fetch_i1_valid,
   input  logic                 dbg_inject_valid,
   input  logic                 decode_i0,
   input  logic                 decode_i1,
   output logic [`IB_DEPTH-1:0] ib_valid,
   output logic [3:0]           wr_i0,     // lane i0 into entry n
   output logic [3:1]           wr_i1,     // lane i1 never lands in entry 0
   output logic                 wr_dbg,
   output logic                 sh_1to0,
   output logic                 sh_2to1,
   output logic                 sh_3to2,
   output logic                 sh_2to0,
   output logic                 sh_3to1
);

   logic                 flush_q;
   ib_pkg::shift_e       shift;
   logic                 i0_ok;
   logic                 i1_ok;
   logic [`IB_DEPTH-1:0] sh_val;    // valids after this cycle's retirement
   logic [`IB_DEPTH-1:0] valid_d;

   always_ff @(posedge clk) begin
      if (reset) flush_q <= 1'b0;
      else flush_q <= flush;
   end

   always_comb begin
      if (decode_i0 && decode_i1) shift = ib_pkg::SHIFT_TWO;
      else if (decode_i0) shift = ib_pkg::SHIFT_ONE;
      else shift = ib_pkg::SHIFT_NONE;
   end

   // room is judged on the valids before the shift
   assign i0_ok = fetch_i0_valid & ~ib_valid[3] & ~flush_q;
   assign i1_ok = fetch_i1_valid & ~ib_valid[2] & ~flush_q;

   always_comb begin
      case (shift)
         ib_pkg::SHIFT_ONE: sh_val = {1'b0, ib_valid[`IB_DEPTH-1:1]};
         ib_pkg::SHIFT_TWO: sh_val = {2'b0, ib_valid[`IB_DEPTH-1:2]};
         default:           sh_val = ib_valid;
      endcase
   end

   // first free slot after the shift takes i0, the one behind it takes i1
   assign wr_i0[0] = ~sh_val[0] & i0_ok;
   assign wr_i0[1] =  sh_val[0] & ~sh_val[1] & i0_ok;
   assign wr_i0[2] =  sh_val[1] & ~sh_val[2] & i0_ok;
   assign wr_i0[3] =  sh_val[2] & ~sh_val[3] & i0_ok;

   assign wr_i1[1] = ~sh_val[0] & i1_ok;
   assign wr_i1[2] =  sh_val[0] & ~sh_val[1] & i1_ok;
   assign wr_i1[3] =  sh_val[1] & ~sh_val[2] & i1_ok;

   assign wr_dbg = ~sh_val[0] & dbg_inject_valid;   // debugger waits for an empty buffer

   // data moves only out of occupied entries
   assign sh_1to0 = (shift == ib_pkg::SHIFT_ONE) & ib_valid[1];
   assign sh_2to1 = (shift == ib_pkg::SHIFT_ONE) & ib_valid[2];
   assign sh_3to2 = (shift == ib_pkg::SHIFT_ONE) & ib_valid[3];
   assign sh_2to0 = (shift == ib_pkg::SHIFT_TWO) & ib_valid[2];
   assign sh_3to1 = (shift == ib_pkg::SHIFT_TWO) & ib_valid[3];

   assign valid_d = (sh_val | wr_i0 | {wr_i1, 1'b0} | {3'b0, wr_dbg}) & ~{`IB_DEPTH{flush_q}};

   always_ff @(posedge clk) begin
      if (reset) ib_valid <= '0;
      else ib_valid <= valid_d;
   end

endmodule

// File: hw/ib_entry_array.sv
// four payload registers of the instruction buffer, loaded and shifted under the slot selects
`timescale 1ns/100ps
`include "ib_defs.svh"

module ib_entry_array (
   input  logic                clk,
   input  logic                reset,
   input  logic [3:0]          wr_i0,
   input  logic [3:1]          wr_i1,
   input  logic                wr_dbg,
   input  logic                sh_1to0,
   input  logic                sh_2to1,
   input  logic                sh_3to2,
   input  logic                sh_2to0,
   input  logic                sh_3to1,
   input  logic [`INSTR_W-1:0] fetch_i0_instr,
   input  logic [`INSTR_W-1:0] fetch_i1_instr,
   input  logic [`PC_W-1:0]    fetch_i0_pc,
   input  logic [`PC_W-1:0]    fetch_i1_pc,
   input  logic                fetch_i0_pc4,
   input  logic                fetch_i1_pc4,
   input  logic                fetch_i0_icaf,
   input  logic                fetch_i1_icaf,
   input  logic [`INSTR_W-1:0] dbg_inject_instr,
   output logic [`INSTR_W-1:0] i0_instr,
   output logic [`INSTR_W-1:0] i1_instr,
   output logic [`PC_W-1:0]    i0_pc,
   output logic [`PC_W-1:0]    i1_pc,
   output logic                i0_pc4,
   output logic                i1_pc4,
   output logic                i0_icaf,
   output logic                i1_icaf
);

   ib_pkg::entry_t       lane0;
   ib_pkg::entry_t       lane1;
   ib_pkg::entry_t       dbg_ent;
   ib_pkg::entry_t       ent_q [`IB_DEPTH];
   ib_pkg::entry_t       ent_d [`IB_DEPTH];
   logic [`IB_DEPTH-1:0] ent_en;

   assign lane0 = '{instr: fetch_i0_instr, pc: fetch_i0_pc,
                    pc4: fetch_i0_pc4, icaf: fetch_i0_icaf};
   assign lane1 = '{instr: fetch_i1_instr, pc: fetch_i1_pc,
                    pc4: fetch_i1_pc4, icaf: fetch_i1_icaf};
   assign dbg_ent = '{instr: dbg_inject_instr, pc: '0, pc4: 1'b0, icaf: 1'b0};  // no fetch side info

   assign ent_en[0] = wr_dbg | wr_i0[0] | sh_1to0 | sh_2to0;
   assign ent_en[1] = wr_i0[1] | wr_i1[1] | sh_2to1 | sh_3to1;
   assign ent_en[2] = wr_i0[2] | wr_i1[2] | sh_3to2;
   assign ent_en[3] = wr_i0[3] | wr_i1[3];   // tail only ever gets written

   // selects are one-hot per entry, the order below only picks among them
   always_comb begin
      if (wr_dbg) ent_d[0] = dbg_ent;
      else if (wr_i0[0]) ent_d[0] = lane0;
      else if (sh_1to0) ent_d[0] = ent_q[1];
      else ent_d[0] = ent_q[2];

      if (wr_i0[1]) ent_d[1] = lane0;
      else if (wr_i1[1]) ent_d[1] = lane1;
      else if (sh_2to1) ent_d[1] = ent_q[2];
      else ent_d[1] = ent_q[3];

      if (wr_i0[2]) ent_d[2] = lane0;
      else if (wr_i1[2]) ent_d[2] = lane1;
      else ent_d[2] = ent_q[3];

      if (wr_i0[3]) ent_d[3] = lane0;
      else ent_d[3] = lane1;
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < `IB_DEPTH; k++) begin
         if (reset) ent_q[k] <= '0;
         else if (ent_en[k]) ent_q[k] <= ent_d[k];
      end
   end

   // decode always sees the two oldest entries
   assign i0_instr = ent_q[0].instr;
   assign i0_pc    = ent_q[0].pc;
   assign i0_pc4   = ent_q[0].pc4;
   assign i0_icaf  = ent_q[0].icaf;

   assign i1_instr = ent_q[1].instr;
   assign i1_pc    = ent_q[1].pc;
   assign i1_pc4   = ent_q[1].pc4;
   assign i1_icaf  = ent_q[1].icaf;

endmodule

// File: hw/inst_buf.sv
// instruction buffer top between dual-lane fetch and dual-issue decode, with debug injection
`timescale 1ns/100ps
`include "ib_defs.svh"

module inst_buf (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 flush,
   input  logic                 fetch_i0_valid,
   input  logic                 fetch_i1_valid,
   input  logic [`INSTR_W-1:0]  fetch_i0_instr,
   input  logic [`INSTR_W-1:0]  fetch_i1_instr,
   input  logic [`PC_W-1:0]     fetch_i0_pc,
   input  logic [`PC_W-1:0]     fetch_i1_pc,
   input  logic                 fetch_i0_pc4,
   input  logic                 fetch_i1_pc4,
   input  logic                 fetch_i0_icaf,
   input  logic                 fetch_i1_icaf,
   input  logic                 decode_i0,
   input  logic                 decode_i1,
   input  logic                 dbg_cmd_valid,
   input  logic                 dbg_cmd_write,
   input  dbg_pkg::dbg_type_e   dbg_cmd_type,
   input  logic [11:0]          dbg_cmd_addr,
   output logic [`IB_DEPTH-1:0] ib_valid,
   output logic [`INSTR_W-1:0]  i0_instr,
   output logic [`INSTR_W-1:0]  i1_instr,
   output logic [`PC_W-1:0]     i0_pc,
   output logic [`PC_W-1:0]     i1_pc,
   output logic                 i0_pc4,
   output logic                 i1_pc4,
   output logic                 i0_icaf,
   output logic                 i1_icaf,
   output logic                 dbg_wdata_rs1,
   output logic                 dbg_fence
);

   logic                dbg_inject_valid;
   logic [`INSTR_W-1:0] dbg_inject_instr;
   logic [3:0]          wr_i0;
   logic [3:1]          wr_i1;
   logic                wr_dbg;
   logic                sh_1to0, sh_2to1, sh_3to2;   // shift by one
   logic                sh_2to0, sh_3to1;            // shift by two

   dbg_inst_gen u_dbg_inst_gen (
      .clk              (clk),
      .reset            (reset),
      .dbg_cmd_valid    (dbg_cmd_valid),
      .dbg_cmd_write    (dbg_cmd_write),
      .dbg_cmd_type     (dbg_cmd_type),
      .dbg_cmd_addr     (dbg_cmd_addr),
      .dbg_inject_valid (dbg_inject_valid),
      .dbg_inject_instr (dbg_inject_instr),
      .dbg_wdata_rs1    (dbg_wdata_rs1),
      .dbg_fence        (dbg_fence)
   );

   ib_slot_ctl u_ib_slot_ctl (
      .clk              (clk),
      .reset            (reset),
      .flush            (flush),
      .fetch_i0_valid   (fetch_i0_valid),
      .fetch_i1_valid   (fetch_i1_valid),
      .dbg_inject_valid (dbg_inject_valid),
      .decode_i0        (decode_i0),
      .decode_i1        (decode_i1),
      .ib_valid         (ib_valid),
      .wr_i0            (wr_i0),
      .wr_i1            (wr_i1),
      .wr_dbg           (wr_dbg),
      .sh_1to0          (sh_1to0),
      .sh_2to1          (sh_2to1),
      .sh_3to2          (sh_3to2),
      .sh_2to0          (sh_2to0),
      .sh_3to1          (sh_3to1)
   );

   ib_entry_array u_ib_entry_array (
      .clk              (clk),
      .reset            (reset),
      .wr_i0            (wr_i0),
      .wr_i1            (wr_i1),
      .wr_dbg           (wr_dbg),
      .sh_1to0          (sh_1to0),
      .sh_2to1          (sh_2to1),
      .sh_3to2          (sh_3to2),
      .sh_2to0          (sh_2to0),
      .sh_3to1          (sh_3to1),
      .fetch_i0_instr   (fetch_i0_instr),
      .fetch_i1_instr   (fetch_i1_instr),
      .fetch_i0_pc      (fetch_i0_pc),
      .fetch_i1_pc      (fetch_i1_pc),
      .fetch_i0_pc4     (fetch_i0_pc4),
      .fetch_i1_pc4     (fetch_i1_pc4),
      .fetch_i0_icaf    (fetch_i0_icaf),
      .fetch_i1_icaf    (fetch_i1_icaf),
      .dbg_inject_instr (dbg_inject_instr),
      .i0_instr         (i0_instr),
      .i1_instr         (i1_instr),
      .i0_pc            (i0_pc),
      .i1_pc            (i1_pc),
      .i0_pc4           (i0_pc4),
      .i1_pc4           (i1_pc4),
      .i0_icaf          (i0_icaf),
      .i1_icaf          (i1_icaf)
   );

endmodule

// File: verif/ib_properties.sv
// slot controller assertions, bound into every ib_slot_ctl instance
`timescale 1ns/100ps
`include "ib_defs.svh"

module ib_properties (
   input logic                 clk,
   input logic                 reset,
   input logic                 flush,
   input logic [`IB_DEPTH-1:0] ib_valid,
   input logic [`IB_DEPTH-1:0] sh_val,    // valids after the retire shift
   input logic                 dbg_inject_valid
);

   // occupied entries always start at the head with no holes
   valid_contiguous: assert property (@(posedge clk) disable iff (reset)
      ib_valid inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
      else $error("ib_valid not contiguous from entry 0: %b", ib_valid);

   // flush is registered first, so the valids clear on the second edge
   flush_clears: assert property (@(posedge clk) disable iff (reset)
      flush |=> ##1 (ib_valid == '0))
      else $error("valids not cleared one edge after the registered flush");

   // head must be free when the debug instruction lands
   dbg_head_free: assert property (@(posedge clk) disable iff (reset)
      dbg_inject_valid |-> !sh_val[0])
      else $error("debug request while entry 0 stays occupied");

endmodule

// File: verif/ib_checker.sv
// watches the buffer ports, runs a queue model and reports every output that differs from it
`timescale 1ns/100ps
`include "ib_defs.svh"

module ib_checker (
   input logic                 clk,
   input logic                 reset,
   input logic                 flush,
   input logic                 fetch_i0_valid, fetch_i1_valid,
   input logic [`INSTR_W-1:0]  fetch_i0_instr, fetch_i1_instr,
   input logic [`PC_W-1:0]     fetch_i0_pc, fetch_i1_pc,
   input logic                 fetch_i0_pc4, fetch_i1_pc4,
   input logic                 fetch_i0_icaf, fetch_i1_icaf,
   input logic                 decode_i0, decode_i1,
   input logic                 dbg_cmd_valid, dbg_cmd_write,
   input dbg_pkg::dbg_type_e   dbg_cmd_type,
   input logic [11:0]          dbg_cmd_addr,
   input logic [`IB_DEPTH-1:0] ib_valid,
   input logic [`INSTR_W-1:0]  i0_instr, i1_instr,
   input logic [`PC_W-1:0]     i0_pc, i1_pc,
   input logic                 i0_pc4, i1_pc4,
   input logic                 i0_icaf, i1_icaf,
   input logic                 dbg_wdata_rs1, dbg_fence
);

   typedef struct packed {
      logic [2:0]                        cnt;
      ib_pkg::entry_t [`IB_DEPTH-1:0]    ent;   // ent[0] is the oldest
   } model_t;

   model_t model;
   logic   model_ok = 1'b0;
   logic   exp_flush_q;
   logic   exp_rs1;
   logic   exp_fence;
   int     error_count = 0;

   function automatic dbg_pkg::dbg_op_e dbg_classify(logic v, logic wr, dbg_pkg::dbg_type_e t);
      if (!v) return dbg_pkg::OP_NONE;
      if (t == dbg_pkg::DBG_GPR) return wr ? dbg_pkg::OP_GPR_WR : dbg_pkg::OP_GPR_RD;
      if (t == dbg_pkg::DBG_CSR) return wr ? dbg_pkg::OP_CSR_WR : dbg_pkg::OP_CSR_RD;
      return dbg_pkg::OP_NONE;
   endfunction

   // riscv encodings, or is funct3 6 op 0x33, csrrw/csrrs funct3 1/2 op 0x73
   function automatic logic [31:0] dbg_encode(dbg_pkg::dbg_op_e op, logic [11:0] a);
      case (op)
         dbg_pkg::OP_GPR_RD: return (32'(a[4:0]) << 15) | (32'd6 << 12) | 32'h33;
         dbg_pkg::OP_GPR_WR: return (32'(a[4:0]) << 7) | (32'd6 << 12) | 32'h33;
         dbg_pkg::OP_CSR_RD: return (32'(a) << 20) | (32'd2 << 12) | 32'h73;
         dbg_pkg::OP_CSR_WR: return (32'(a) << 20) | (32'd1 << 12) | 32'h73;
         default:            return 32'h0;
      endcase
   endfunction

   function automatic model_t next_model(model_t m, logic fq, logic f0, logic f1,
                                         ib_pkg::entry_t l0, ib_pkg::entry_t l1,
                                         logic d0, logic d1, logic inj, ib_pkg::entry_t de);
      model_t n;
      int     drop;
      int     c;
      logic   ok0;
      logic   ok1;
      ok0 = f0 && m.cnt < 3'd4 && !fq;   // room judged before retirement
      ok1 = f1 && m.cnt < 3'd3 && !fq;
      drop = d0 ? (d1 ? 2 : 1) : 0;
      if (drop > int'(m.cnt)) drop = int'(m.cnt);
      for (int k = 0; k < `IB_DEPTH; k++) begin
         if (k + drop < `IB_DEPTH) n.ent[k] = m.ent[k + drop];
         else n.ent[k] = '0;
      end
      c = int'(m.cnt) - drop;
      if (fq) c = 0;
      else begin
         if (inj && c == 0) begin
            n.ent[0] = de;
            c = 1;
         end
         if (ok0) begin
            n.ent[c] = l0;
            c++;
         end
         if (ok1) begin
            n.ent[c] = l1;
            c++;
         end
      end
      n.cnt = 3'(c);
      return n;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
         error_count++;
      end
   endtask

   always @(posedge clk) begin
      ib_pkg::entry_t   l0;
      ib_pkg::entry_t   l1;
      ib_pkg::entry_t   de;
      dbg_pkg::dbg_op_e op;
      logic [3:0]       ev;
      logic             reg_cmd;
      ev = '0;
      for (int k = 0; k < `IB_DEPTH; k++) ev[k] = (k < int'(model.cnt));
      if (model_ok && !reset) begin
         check_value("ib_valid", 32'(ev), 32'(ib_valid));
         check_value("dbg_wdata_rs1", 32'(exp_rs1), 32'(dbg_wdata_rs1));
         check_value("dbg_fence", 32'(exp_fence), 32'(dbg_fence));
         if (ev[0]) begin
            check_value("i0_instr", model.ent[0].instr, i0_instr);
            check_value("i0_pc", 32'(model.ent[0].pc), 32'(i0_pc));
            check_value("i0_pc4", 32'(model.ent[0].pc4), 32'(i0_pc4));
            check_value("i0_icaf", 32'(model.ent[0].icaf), 32'(i0_icaf));
         end
         if (ev[1]) begin
            check_value("i1_instr", model.ent[1].instr, i1_instr);
            check_value("i1_pc", 32'(model.ent[1].pc), 32'(i1_pc));
            check_value("i1_pc4", 32'(model.ent[1].pc4), 32'(i1_pc4));
            check_value("i1_icaf", 32'(model.ent[1].icaf), 32'(i1_icaf));
         end
      end
      if (reset) begin
         model = '0;
         model_ok = 1'b1;
         exp_flush_q = 1'b0;
         exp_rs1 = 1'b0;
         exp_fence = 1'b0;
      end else begin
         op = dbg_classify(dbg_cmd_valid, dbg_cmd_write, dbg_cmd_type);
         l0 = '{instr: fetch_i0_instr, pc: fetch_i0_pc, pc4: fetch_i0_pc4, icaf: fetch_i0_icaf};
         l1 = '{instr: fetch_i1_instr, pc: fetch_i1_pc, pc4: fetch_i1_pc4, icaf: fetch_i1_icaf};
         de = '{instr: dbg_encode(op, dbg_cmd_addr), pc: '0, pc4: 1'b0, icaf: 1'b0};
         model = next_model(model, exp_flush_q, fetch_i0_valid, fetch_i1_valid, l0, l1,
                            decode_i0, decode_i1, op != dbg_pkg::OP_NONE, de);
         exp_flush_q = flush;
         // memory commands never reach the buffer, so they raise no flag
         reg_cmd = (dbg_cmd_type == dbg_pkg::DBG_GPR) || (dbg_cmd_type == dbg_pkg::DBG_CSR);
         exp_rs1 = dbg_cmd_valid && dbg_cmd_write && reg_cmd;
         exp_fence = dbg_cmd_valid && dbg_cmd_write && (dbg_cmd_type == dbg_pkg::DBG_CSR)
                     && (dbg_cmd_addr == `DBG_FENCE_CSR);
      end
   end

endmodule

// File: verif/tb_inst_buf.sv
// testbench top for the instruction buffer, drives random fetch, decode, flush and debug traffic
`timescale 1ns/100ps
`include "ib_defs.svh"

module tb_inst_buf;

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 flush;
   logic                 fetch_i0_valid, fetch_i1_valid;
   logic [`INSTR_W-1:0]  fetch_i0_instr, fetch_i1_instr;
   logic [`PC_W-1:0]     fetch_i0_pc, fetch_i1_pc;
   logic                 fetch_i0_pc4, fetch_i1_pc4;
   logic                 fetch_i0_icaf, fetch_i1_icaf;
   logic                 decode_i0, decode_i1;
   logic                 dbg_cmd_valid, dbg_cmd_write;
   dbg_pkg::dbg_type_e   dbg_cmd_type;
   logic [11:0]          dbg_cmd_addr;
   logic [`IB_DEPTH-1:0] ib_valid;
   logic [`INSTR_W-1:0]  i0_instr, i1_instr;
   logic [`PC_W-1:0]     i0_pc, i1_pc;
   logic                 i0_pc4, i1_pc4;
   logic                 i0_icaf, i1_icaf;
   logic                 dbg_wdata_rs1, dbg_fence;

   integer seed;
   int     timeout_count;

   always #2 clk = ~clk;   // 4 ns period

   inst_buf DUT (.*);

   ib_checker chk (.*);

   bind ib_slot_ctl ib_properties u_props (
      .clk              (clk),
      .reset            (reset),
      .flush            (flush),
      .ib_valid         (ib_valid),
      .sh_val           (sh_val),
      .dbg_inject_valid (dbg_inject_valid)
   );

   task automatic drive_idle();
      fetch_i0_valid <= 1'b0;
      fetch_i1_valid <= 1'b0;
      decode_i0      <= 1'b0;
      decode_i1      <= 1'b0;
      flush          <= 1'b0;
      dbg_cmd_valid  <= 1'b0;
   endtask

   // i1 is only ever offered together with i0
   task automatic drive_fetch(input logic two);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      fetch_i0_valid <= 1'b1;
      fetch_i1_valid <= two;
      fetch_i0_instr <= a;
      fetch_i1_instr <= b;
      fetch_i0_pc    <= c[30:0];
      fetch_i1_pc    <= c[30:0] + 31'd2;
      fetch_i0_pc4   <= a[0];
      fetch_i1_pc4   <= b[0];
      fetch_i0_icaf  <= (a[7:4] == 4'd0);   // faults are rare
      fetch_i1_icaf  <= (b[7:4] == 4'd0);
   endtask

   // active edge then idle edge, so the valids read at the active edge are current
   // fmode 0 none, 1 random, 2 dual; dmode 0 none, 1 random, 2 max, 3 one only
   task automatic op_cycle(input int fmode, input int dmode, output logic [3:0] v);
      logic [31:0] r;
      @(posedge clk);
      v = ib_valid;
      r = $random(seed);
      drive_idle();
      if (v[0] && (dmode == 2 || dmode == 3 || (dmode == 1 && r[0]))) begin
         decode_i0 <= 1'b1;
         decode_i1 <= v[1] && dmode != 3 && (dmode == 2 || r[1]);
      end
      if (fmode == 2 || (fmode == 1 && r[2])) drive_fetch(fmode == 2 || r[3]);
      @(posedge clk);
      drive_idle();
   endtask

   task automatic flush_op();
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      drive_idle();
      drive_fetch(1'b1);   // offered right behind the flush, must be dropped
      @(posedge clk);
      drive_idle();
   endtask

   task automatic debug_op(input logic wr, input dbg_pkg::dbg_type_e t, input logic [11:0] a);
      logic [3:0] v;
      int         n;
      n = 0;
      v = 4'hf;
      while (v != 4'b0 && n < 20) begin
         op_cycle(0, 2, v);
         n++;
      end
      if (v != 4'b0) begin
         $display("Timeout: buffer did not drain before a debug command");
         timeout_count++;
      end else begin
         @(posedge clk);
         dbg_cmd_valid <= 1'b1;
         dbg_cmd_write <= wr;
         dbg_cmd_type  <= t;
         dbg_cmd_addr  <= a;
         @(posedge clk);
         drive_idle();
         @(posedge clk);   // flags show up here
      end
   endtask

   initial begin
      logic [3:0]  v;
      logic [31:0] r;
      int          n;
      seed = 32'h2c3a_cbcb;
      timeout_count = 0;
      reset = 1'b1;
      flush = 1'b0;
      fetch_i0_valid = 1'b0;
      fetch_i1_valid = 1'b0;
      fetch_i0_instr = '0;
      fetch_i1_instr = '0;
      fetch_i0_pc = '0;
      fetch_i1_pc = '0;
      fetch_i0_pc4 = 1'b0;
      fetch_i1_pc4 = 1'b0;
      fetch_i0_icaf = 1'b0;
      fetch_i1_icaf = 1'b0;
      decode_i0 = 1'b0;
      decode_i1 = 1'b0;
      dbg_cmd_valid = 1'b0;
      dbg_cmd_write = 1'b0;
      dbg_cmd_type = dbg_pkg::DBG_GPR;
      dbg_cmd_addr = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      n = 0;
      v = 4'b0;
      while (v != 4'hf && n < 10) begin   // fill with no decode
         op_cycle(2, 0, v);
         n++;
      end
      if (v != 4'hf) begin
         $display("Timeout: buffer never filled under dual fetch");
         timeout_count++;
      end
      repeat (3) op_cycle(2, 0, v);   // full, both lanes refused
      op_cycle(0, 3, v);
      repeat (2) op_cycle(2, 0, v);   // three-full takes i0 only

      repeat (400) begin
         r = $random(seed);
         if (r[3:0] == 4'd0) flush_op();
         else op_cycle(1, 1, v);
      end

      debug_op(1'b0, dbg_pkg::DBG_GPR, 12'h00b);
      debug_op(1'b1, dbg_pkg::DBG_GPR, 12'h01f);
      debug_op(1'b0, dbg_pkg::DBG_CSR, 12'h341);
      debug_op(1'b1, dbg_pkg::DBG_CSR, 12'h7c4);
      debug_op(1'b1, dbg_pkg::DBG_CSR, 12'h7c5);
      debug_op(1'b1, dbg_pkg::DBG_MEM, 12'h7c4);
      repeat (4) @(posedge clk);

      $display("errors: %0d compare, %0d timeout", chk.error_count, timeout_count);
      if (chk.error_count == 0 && timeout_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+hw
hw/ib_pkg.sv
hw/dbg_pkg.sv
hw/dbg_inst_gen.sv
hw/ib_slot_ctl.sv
hw/ib_entry_array.sv
hw/inst_buf.sv
verif/ib_properties.sv
verif/ib_checker.sv
verif/tb_inst_buf.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the instruction buffer regression with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_inst_buf \
   -Mdir obj_dir

./obj_dir/Vtb_inst_buf 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0
